/* anim_pkg.sv */
`default_nettype none

package anim_pkg;

    // field widths
    localparam int ANIM_W  = 3;   // animation select, ui_in[7:5]
    localparam int SPEED_W = 5;   // speed field, ui_in[4:0]
    localparam int FRAME_W = 4;   // frame index, hex needs 16 frames
    localparam int TICK_W  = 24;  // tick counter
    localparam int SEG_W   = 7;   // segments a..g, bit 0 is a

    // one frame per second at a 10 MHz clock
    localparam logic [TICK_W-1:0] DEFAULT_PERIOD = 24'd9_999_999;

    // nonzero speed s gives a compare value of s << 10
    localparam int SPEED_SHIFT = 10;

    // animation select, encoding follows the switch value
    typedef enum logic [ANIM_W-1:0] {
        ANIM_DIGITS = 3'd0,  // 0..9
        ANIM_HEX    = 3'd1,  // 0..F
        ANIM_SPIN   = 3'd2,  // one outer segment going round clockwise
        ANIM_SNAKE  = 3'd3,  // figure eight
        ANIM_FILL   = 3'd4,  // fill bottom to top
        ANIM_BLINK  = 3'd5,  // all on, all off
        ANIM_BARS   = 3'd6,  // horizontal bar moving down
        ANIM_BLANK  = 3'd7   // display dark
    } anim_e;

    // frames per animation
    localparam int FRAMES_DIGITS = 10;
    localparam int FRAMES_HEX    = 16;
    localparam int FRAMES_SPIN   = 6;
    localparam int FRAMES_SNAKE  = 8;
    localparam int FRAMES_FILL   = 4;
    localparam int FRAMES_BLINK  = 2;
    localparam int FRAMES_BARS   = 3;
    localparam int FRAMES_BLANK  = 1;

    // single segment masks, a set bit lights the segment
    localparam logic [SEG_W-1:0] SEG_A   = 7'h01;  // top
    localparam logic [SEG_W-1:0] SEG_B   = 7'h02;  // top right
    localparam logic [SEG_W-1:0] SEG_C   = 7'h04;  // bottom right
    localparam logic [SEG_W-1:0] SEG_D   = 7'h08;  // bottom
    localparam logic [SEG_W-1:0] SEG_E   = 7'h10;  // bottom left
    localparam logic [SEG_W-1:0] SEG_F   = 7'h20;  // top left
    localparam logic [SEG_W-1:0] SEG_G   = 7'h40;  // middle
    localparam logic [SEG_W-1:0] SEG_ALL = 7'h7F;
    localparam logic [SEG_W-1:0] SEG_OFF = 7'h00;

endpackage : anim_pkg

`default_nettype wire

/* anim_decode.sv */
`timescale 1ns/10ps
`default_nettype none

// switch decoding, purely combinational
// turns the raw switch fields into what the sequencer compares against
module anim_decode (
    input  logic [anim_pkg::ANIM_W-1:0]  anim_sel,        // ui_in[7:5]
    input  logic [anim_pkg::SPEED_W-1:0] speed,           // ui_in[4:0]
    input  logic [anim_pkg::TICK_W-1:0]  default_period,  // used when speed is 0
    output anim_pkg::anim_e              anim,
    output logic [anim_pkg::FRAME_W-1:0] last_frame,      // frame count minus 1
    output logic [anim_pkg::TICK_W-1:0]  compare          // tick value that ends a frame
);

    logic [anim_pkg::TICK_W-1:0] speed_scaled;  // speed widened and shifted

    // switch value maps one to one onto the enum
    assign anim = anim_pkg::anim_e'(anim_sel);

    // frame count lookup
    always_comb begin
        case (anim)
            anim_pkg::ANIM_DIGITS:
                last_frame = anim_pkg::FRAME_W'(anim_pkg::FRAMES_DIGITS - 1);
            anim_pkg::ANIM_HEX:
                last_frame = anim_pkg::FRAME_W'(anim_pkg::FRAMES_HEX - 1);
            anim_pkg::ANIM_SPIN:
                last_frame = anim_pkg::FRAME_W'(anim_pkg::FRAMES_SPIN - 1);
            anim_pkg::ANIM_SNAKE:
                last_frame = anim_pkg::FRAME_W'(anim_pkg::FRAMES_SNAKE - 1);
            anim_pkg::ANIM_FILL:
                last_frame = anim_pkg::FRAME_W'(anim_pkg::FRAMES_FILL - 1);
            anim_pkg::ANIM_BLINK:
                last_frame = anim_pkg::FRAME_W'(anim_pkg::FRAMES_BLINK - 1);
            anim_pkg::ANIM_BARS:
                last_frame = anim_pkg::FRAME_W'(anim_pkg::FRAMES_BARS - 1);
            anim_pkg::ANIM_BLANK:
                last_frame = anim_pkg::FRAME_W'(anim_pkg::FRAMES_BLANK - 1);
            default:
                last_frame = '0;  // single frame, unreachable with a 3 bit enum
        endcase
    end

    // speed of 31 gives 31744, well inside 24 bits
    assign speed_scaled = anim_pkg::TICK_W'(speed) << anim_pkg::SPEED_SHIFT;

    // zero speed falls back to the default period
    assign compare = (speed == '0) ? default_period : speed_scaled;

endmodule : anim_decode

`default_nettype wire

/* frame_sequencer.sv */
`timescale 1ns/10ps
`default_nettype none

// frame sequencing
// tick counts 0..compare, so a frame lasts compare+1 cycles
// frame counts 0..last_frame and then wraps
module frame_sequencer (
    input  logic                         clk,
    input  logic                         rst_n,
    input  anim_pkg::anim_e              anim,        // current selection
    input  logic [anim_pkg::FRAME_W-1:0] last_frame,  // index of last frame of anim
    input  logic [anim_pkg::TICK_W-1:0]  compare,     // end of frame tick value
    output logic [anim_pkg::FRAME_W-1:0] frame,
    output logic [anim_pkg::TICK_W-1:0]  tick
);

    anim_pkg::anim_e             prev_anim;   // selection seen last cycle
    logic                        anim_change; // selection differs from last cycle
    logic                        frame_end;   // last tick of the current frame
    logic                        frame_wrap;  // current frame is the last one
    logic [anim_pkg::FRAME_W-1:0] frame_next;

    assign anim_change = (anim != prev_anim);
    assign frame_end   = (tick == compare);
    assign frame_wrap  = (frame == last_frame);  // only wrap test in the design

    // next frame index, used on frame_end only
    assign frame_next = frame_wrap ? '0 : frame + 1'b1;

    // previous selection, also loaded during reset
    // so the first cycle after reset sees no change
    always_ff @(posedge clk) begin
        prev_anim <= anim;
    end

    // tick counter
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            tick <= '0;
        end else if (anim_change) begin
            tick <= '0;                 // restart the new animation
        end else if (frame_end) begin
            tick <= '0;                 // start of next frame
        end else begin
            tick <= tick + 1'b1;
        end
    end

    // frame counter
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            frame <= '0;
        end else if (anim_change) begin
            frame <= '0;                // new animation starts at its frame 0
        end else if (frame_end) begin
            frame <= frame_next;
        end
    end

endmodule : frame_sequencer

`default_nettype wire

/* segment_rom.sv */
`timescale 1ns/10ps
`default_nettype none

// segment pattern lookup, combinational
// bit 0 is segment a, bit 6 is segment g, 1 lights the segment
module segment_rom (
    input  anim_pkg::anim_e              anim,
    input  logic [anim_pkg::FRAME_W-1:0] frame,
    output logic [anim_pkg::SEG_W-1:0]   segments
);

    logic [anim_pkg::SEG_W-1:0] font;  // hex glyph of frame, shared by digits and hex

    // hex font, 0..F
    always_comb begin
        case (frame)
            4'h0:    font = 7'h3F;  // a b c d e f
            4'h1:    font = 7'h06;  // b c
            4'h2:    font = 7'h5B;  // a b d e g
            4'h3:    font = 7'h4F;  // a b c d g
            4'h4:    font = 7'h66;  // b c f g
            4'h5:    font = 7'h6D;  // a c d f g
            4'h6:    font = 7'h7D;  // a c d e f g
            4'h7:    font = 7'h07;  // a b c
            4'h8:    font = 7'h7F;  // all
            4'h9:    font = 7'h6F;  // a b c d f g
            4'hA:    font = 7'h77;  // a b c e f g
            4'hB:    font = 7'h7C;  // lower case b
            4'hC:    font = 7'h39;  // a d e f
            4'hD:    font = 7'h5E;  // lower case d
            4'hE:    font = 7'h79;  // a d e f g
            default: font = 7'h71;  // F, a e f g
        endcase
    end

    always_comb begin
        segments = anim_pkg::SEG_OFF;  // unused frame indices stay dark
        case (anim)
            anim_pkg::ANIM_DIGITS: begin
                if (frame < 4'd10)
                    segments = font;  // decimal part of the font only
            end
            anim_pkg::ANIM_HEX: begin
                segments = font;
            end
            anim_pkg::ANIM_SPIN: begin
                // one lit outer segment, clockwise from the top
                case (frame)
                    4'd0:    segments = anim_pkg::SEG_A;
                    4'd1:    segments = anim_pkg::SEG_B;
                    4'd2:    segments = anim_pkg::SEG_C;
                    4'd3:    segments = anim_pkg::SEG_D;
                    4'd4:    segments = anim_pkg::SEG_E;
                    4'd5:    segments = anim_pkg::SEG_F;
                    default: segments = anim_pkg::SEG_OFF;
                endcase
            end
            anim_pkg::ANIM_SNAKE: begin
                // figure eight through the middle bar twice
                case (frame)
                    4'd0:    segments = anim_pkg::SEG_A;
                    4'd1:    segments = anim_pkg::SEG_B;
                    4'd2:    segments = anim_pkg::SEG_G;
                    4'd3:    segments = anim_pkg::SEG_E;
                    4'd4:    segments = anim_pkg::SEG_D;
                    4'd5:    segments = anim_pkg::SEG_C;
                    4'd6:    segments = anim_pkg::SEG_G;
                    4'd7:    segments = anim_pkg::SEG_F;
                    default: segments = anim_pkg::SEG_OFF;
                endcase
            end
            anim_pkg::ANIM_FILL: begin
                // bars accumulate bottom up, last frame lights everything
                case (frame)
                    4'd0: segments = anim_pkg::SEG_D;
                    4'd1: segments = anim_pkg::SEG_D | anim_pkg::SEG_G;
                    4'd2: segments = anim_pkg::SEG_D | anim_pkg::SEG_G | anim_pkg::SEG_A;
                    4'd3: segments = anim_pkg::SEG_ALL;
                    default: segments = anim_pkg::SEG_OFF;
                endcase
            end
            anim_pkg::ANIM_BLINK: begin
                if (frame == 4'd0)
                    segments = anim_pkg::SEG_ALL;  // frame 1 is dark
            end
            anim_pkg::ANIM_BARS: begin
                case (frame)
                    4'd0:    segments = anim_pkg::SEG_A;  // top
                    4'd1:    segments = anim_pkg::SEG_G;  // middle
                    4'd2:    segments = anim_pkg::SEG_D;  // bottom
                    default: segments = anim_pkg::SEG_OFF;
                endcase
            end
            default: begin
                segments = anim_pkg::SEG_OFF;  // blank
            end
        endcase
    end

endmodule : segment_rom

`default_nettype wire

/* seg7_anim_top.sv */
`timescale 1ns/10ps
`default_nettype none

// seven segment animation engine, tile top level
// ui_in[7:5] animation, ui_in[4:0] speed
// uo_out[6:0] segments a..g, uio_out tick low byte
module seg7_anim_top #(
    // compare value when the speed switches are 0
    parameter logic [anim_pkg::TICK_W-1:0] default_period = anim_pkg::DEFAULT_PERIOD
) (
    input  wire [7:0] ui_in,    // switches
    output wire [7:0] uo_out,   // display, bit 7 is the unused decimal point
    input  wire [7:0] uio_in,   // not used
    output wire [7:0] uio_out,  // debug, tick counter
    output wire [7:0] uio_oe,   // all outputs
    input  wire       ena,      // not used
    input  wire       clk,
    input  wire       rst_n
);

    anim_pkg::anim_e              anim;
    logic [anim_pkg::FRAME_W-1:0] last_frame;
    logic [anim_pkg::TICK_W-1:0]  compare;
    logic [anim_pkg::FRAME_W-1:0] frame;
    logic [anim_pkg::TICK_W-1:0]  tick;
    logic [anim_pkg::SEG_W-1:0]   segments;

    // decode
    anim_decode u_decode (
        .anim_sel       (ui_in[7:5]),
        .speed          (ui_in[4:0]),
        .default_period (default_period),
        .anim           (anim),
        .last_frame     (last_frame),
        .compare        (compare)
    );

    // execute
    frame_sequencer u_seq (
        .clk        (clk),
        .rst_n      (rst_n),
        .anim       (anim),
        .last_frame (last_frame),
        .compare    (compare),
        .frame      (frame),
        .tick       (tick)
    );

    // result, follows the frame register with no extra delay
    segment_rom u_rom (
        .anim     (anim),
        .frame    (frame),
        .segments (segments)
    );

    assign uo_out  = {1'b0, segments};  // no decimal point
    assign uio_out = tick[7:0];
    assign uio_oe  = 8'hFF;

endmodule : seg7_anim_top

`default_nettype wire

/* seg7_anim_tb.sv */
`timescale 1ns/10ps
`default_nettype none

// self-checking testbench for the seven segment animation engine
// each row sets ui_in and watches a number of frames, measured at the falling edge
module seg7_anim_tb;

    localparam logic [23:0] SIM_PERIOD = 24'd5;  // short default period for simulation
    localparam int          ROWS       = 16;     // two rows per animation

    logic       clk;
    logic       rst_n;
    logic       ena;
    logic [7:0] ui_in;
    logic [7:0] uio_in;
    wire  [7:0] uo_out;
    wire  [7:0] uio_out;
    wire  [7:0] uio_oe;

    logic [7:0] row_ui     [0:ROWS-1];  // switch setting per row
    int         row_frames [0:ROWS-1];  // frames to observe per row

    int          errors;
    int          checks;
    int          watchdog_cycles;  // 0 until the table is built
    logic [31:0] rng;
    logic [2:0]  cur_anim;         // animation the DUT is running
    int          cur_idx;          // frame index the DUT is showing

    seg7_anim_top #(
        .default_period (SIM_PERIOD)
    ) u_dut (
        .ui_in   (ui_in),
        .uo_out  (uo_out),
        .uio_in  (uio_in),
        .uio_out (uio_out),
        .uio_oe  (uio_oe),
        .ena     (ena),
        .clk     (clk),
        .rst_n   (rst_n)
    );

    // 4 ns clock
    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // frames per animation, by select value
    function automatic int frames_of(input logic [2:0] anim);
        case (anim)
            3'd0:    return 10;  // digits
            3'd1:    return 16;  // hex
            3'd2:    return 6;   // spin
            3'd3:    return 8;   // snake
            3'd4:    return 4;   // fill
            3'd5:    return 2;   // blink
            3'd6:    return 3;   // bars
            default: return 1;   // blank
        endcase
    endfunction

    // cycles per frame, compare value plus one
    function automatic int frame_cycles(input logic [7:0] ui);
        logic [4:0] speed;
        speed = ui[4:0];
        if (speed == 5'd0)
            return int'(SIM_PERIOD) + 1;  // default period
        return int'(speed) * 1024 + 1;
    endfunction

    // reference font, bit 0 = a ... bit 6 = g
    function automatic logic [6:0] hex_glyph(input int idx);
        case (idx)
            0:       return 7'h3F;  // abcdef
            1:       return 7'h06;  // bc
            2:       return 7'h5B;  // abdeg
            3:       return 7'h4F;  // abcdg
            4:       return 7'h66;  // bcfg
            5:       return 7'h6D;  // acdfg
            6:       return 7'h7D;  // acdefg
            7:       return 7'h07;  // abc
            8:       return 7'h7F;
            9:       return 7'h6F;  // abcdfg
            10:      return 7'h77;  // A
            11:      return 7'h7C;  // b
            12:      return 7'h39;  // C
            13:      return 7'h5E;  // d
            14:      return 7'h79;  // E
            default: return 7'h71;  // F
        endcase
    endfunction

    // expected segments for one frame of one animation
    function automatic logic [6:0] expected_pattern(input logic [2:0] anim, input int idx);
        logic [6:0] spin  [0:5];
        logic [6:0] snake [0:7];
        logic [6:0] fill  [0:3];
        logic [6:0] bars  [0:2];
        spin  = '{7'h01, 7'h02, 7'h04, 7'h08, 7'h10, 7'h20};  // a b c d e f
        snake = '{7'h01, 7'h02, 7'h40, 7'h10, 7'h08, 7'h04, 7'h40, 7'h20};
        fill  = '{7'h08, 7'h48, 7'h49, 7'h7F};                // d, +g, +a, all
        bars  = '{7'h01, 7'h40, 7'h08};                       // top, middle, bottom
        case (anim)
            3'd0:    return hex_glyph(idx);
            3'd1:    return hex_glyph(idx);
            3'd2:    return spin[idx];
            3'd3:    return snake[idx];
            3'd4:    return fill[idx];
            3'd5:    return (idx == 0) ? 7'h7F : 7'h00;
            3'd6:    return bars[idx];
            default: return 7'h00;
        endcase
    endfunction

    task automatic check_val(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("** Error: %s is 0x%0h, expected 0x%0h at %0t ns", name, got, exp, $time);
        end
    endtask

    // speed zero row then a random small speed row for every animation
    task automatic build_table();
        logic [4:0] speed;
        int         a;
        rng = 32'hf412742f;
        for (a = 0; a < 8; a++) begin
            rng   = xorshift32(rng);
            speed = rng[0] ? 5'd2 : 5'd1;  // keeps a frame near 1k or 2k cycles
            row_ui[2*a]         = {a[2:0], 5'd0};
            row_frames[2*a]     = (a == 7) ? 4 : 2 * frames_of(a[2:0]);  // two rounds
            row_ui[2*a + 1]     = {a[2:0], speed};
            row_frames[2*a + 1] = (a == 7) ? 3 : frames_of(a[2:0]) + 1;  // ends on frame 1
        end
    endtask

    // enters at a falling edge inside frame cur_pat, at tick value start
    // leaves at the falling edge of the first cycle of the next frame
    task automatic measure_frame(input logic [6:0] cur_pat, input logic [6:0] next_pat,
                                 input int exp_len, input int start);
        int cnt;
        int limit;
        bit done;
        cnt   = start;
        limit = (next_pat == cur_pat) ? exp_len : exp_len + 1;  // blank has no change
        done  = 1'b0;
        check_val("uo_out", uo_out, cur_pat);
        while (!done) begin
            check_val("uio_out", uio_out, cnt & 255);  // tick low byte
            check_val("uo_out[7]", uo_out[7], 0);
            check_val("uio_oe", uio_oe, 8'hFF);
            cnt++;
            @(negedge clk);
            if (uo_out !== {1'b0, cur_pat} || cnt >= limit)
                done = 1'b1;
        end
        check_val("frame length", cnt, exp_len);
        check_val("uo_out", uo_out, next_pat);
    endtask

    task automatic run_row(input int r);
        logic [2:0] anim;
        int         n;
        int         len;
        int         start;
        int         f;
        int         next_idx;
        int         err_before;
        anim       = row_ui[r][7:5];
        n          = frames_of(anim);
        len        = frame_cycles(row_ui[r]);
        err_before = errors;
        @(posedge clk);
        ui_in <= row_ui[r];  // lands on tick 1 of the current frame
        if (anim != cur_anim) begin
            @(posedge clk);   // sequencer sees the change here and restarts
            @(negedge clk);
            cur_anim = anim;
            cur_idx  = 0;
            start    = 0;
        end else begin
            // same animation, the running frame just stretches to the new period
            @(negedge clk);
            start = 1;
        end
        for (f = 0; f < row_frames[r]; f++) begin
            next_idx = (cur_idx + 1) % n;
            measure_frame(expected_pattern(anim, cur_idx), expected_pattern(anim, next_idx),
                          len, start);
            start   = 0;
            cur_idx = next_idx;
        end
        $display("row %0d  ui_in 0x%02h  %0d frames of %0d cycles  %s", r, row_ui[r],
                 row_frames[r], len, (errors == err_before) ? "ok" : "FAILED");
    endtask

    // watchdog, armed once the table gives the run length
    initial begin
        wait (watchdog_cycles > 0);
        repeat (watchdog_cycles) @(posedge clk);
        $display("timeout: run still busy after %0d cycles", watchdog_cycles);
        $display("RESULT: FAIL");
        $finish;
    end

    initial begin
        int r;
        int budget;
        ui_in           = 8'h00;  // digits, default speed during reset
        uio_in          = 8'h00;
        ena             = 1'b1;
        rst_n           = 1'b0;
        errors          = 0;
        checks          = 0;
        cur_anim        = 3'd0;   // prev anim register loads this during reset
        cur_idx         = 0;
        watchdog_cycles = 0;

        build_table();
        budget = 16 + ROWS * 4;  // reset plus row changes
        for (r = 0; r < ROWS; r++)
            budget += row_frames[r] * frame_cycles(row_ui[r]) * 2;
        watchdog_cycles = budget;

        repeat (16) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);  // first cycle of frame 0, tick 0

        for (r = 0; r < ROWS; r++)
            run_row(r);

        $display("%0d rows, %0d checks, %0d errors", ROWS, checks, errors);
        if (errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule : seg7_anim_tb

`default_nettype wire

/* sources.f */
anim_pkg.sv
anim_decode.sv
frame_sequencer.sv
segment_rom.sv
seg7_anim_top.sv
seg7_anim_tb.sv
